/* Bender.yml */
package:
  name: aimbot_video

sources:
  - aimbot_pkg.sv
  - cam_capture.sv
  - line_fifo.sv
  - pixel_combine.sv
  - hsync_gen.sv
  - err_stretch.sv
  - aimbot_video.sv
  - target: test
    files:
      - aimbot_assertions.sv
      - tb_aimbot_video.sv

/* aimbot_assertions.sv */
`timescale 1ns/1ps

module aimbot_assertions import aimbot_pkg::*; #(
    parameter int line_w = 16
) (
    input logic       clk,
    input logic       rst_n,
    input logic       de,
    input logic       hsync,
    input logic       href_1,
    input logic       href_2,
    input logic       err_pulse,
    input logic       err_level,
    input err_cause_t cause
);

    int fail_cnt = 0;

    a_sync_blank: assert property (@(posedge clk) disable iff (!rst_n) !(de && hsync))
        else begin
            fail_cnt++;
            $error("hsync and de high in the same cycle");
        end

    // a line is one unbroken run of line_w pixels
    a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(de) |-> de [*line_w] ##1 !de)
        else begin
            fail_cnt++;
            $error("de run differs from line_w cycles");
        end

    a_err_level: assert property (@(posedge clk) disable iff (!rst_n) err_pulse |=> err_level)
        else begin
            fail_cnt++;
            $error("error pulse not followed by the error level");
        end

    // a length error pulse follows the fall of href on a camera by two cycles
    a_err_cause: assert property (@(posedge clk) disable iff (!rst_n)
        err_pulse && cause == cause_length |->
            ($past(href_1, 3) && !$past(href_1, 2)) || ($past(href_2, 3) && !$past(href_2, 2)))
        else begin
            fail_cnt++;
            $error("length error pulse without a line end on either camera");
        end

endmodule : aimbot_assertions

bind aimbot_video aimbot_assertions #(.line_w(line_w)) u_aimbot_assertions (
    .clk      (clk                  ),
    .rst_n    (rst_n                ),
    .de       (hdmi_de              ),
    .hsync    (hdmi_hsync           ),
    .href_1   (cam1_href            ),
    .href_2   (cam2_href            ),
    .err_pulse(comb_err_p           ),
    .err_level(comb_err             ),
    .cause    (u_pixel_combine.cause)
);

/* aimbot_pkg.sv */
package aimbot_pkg;

    // one RGB565 pixel, r in the top five bits
    localparam int pix_w = 16;

    // combiner FSM
    typedef enum logic [1:0] {
        st_idle,    // waiting for a line on both cameras
        st_stream,  // popping both FIFOs in lockstep
        st_gap      // last pixel on the output, de drops next
    } comb_state_t;

    // last reason the combiner raised its error pulse
    typedef enum logic [1:0] {
        cause_none,
        cause_overflow,
        cause_length
    } err_cause_t;

endpackage : aimbot_pkg

/* aimbot_video.sv */
`timescale 1ns/1ps

module aimbot_video import aimbot_pkg::*; #(
    parameter int line_w     = 16,
    parameter int fifo_depth = 64,
    parameter int h_fp       = 4,
    parameter int h_sync     = 3,
    parameter int err_hold   = 20
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             cam1_vsync,
    input  logic             cam1_href,
    input  logic             cam1_pclk,
    input  logic [7:0]       cam1_data,

    input  logic             cam2_vsync,
    input  logic             cam2_href,
    input  logic             cam2_pclk,
    input  logic [7:0]       cam2_data,

    output logic             hdmi_de,
    output logic             hdmi_hsync,
    output logic             hdmi_vsync,
    output logic [7:0]       hdmi_r,
    output logic [7:0]       hdmi_g,
    output logic [7:0]       hdmi_b,
    output logic [pix_w-1:0] aux_pix,
    output logic             comb_err
);

    logic             cam1_pix_valid, cam2_pix_valid;
    logic [pix_w-1:0] cam1_pix, cam2_pix;
    logic             cam1_line_done, cam2_line_done;
    logic             cam1_len_err, cam2_len_err;
    logic             comb_valid;
    logic             comb_err_p;
    logic [pix_w-1:0] comb_pix_1, comb_pix_2;

    cam_capture #(.line_w(line_w)) u_cam1_capture (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .href     (cam1_href     ),
        .pclk     (cam1_pclk     ),
        .data     (cam1_data     ),
        .pix_valid(cam1_pix_valid),
        .pix      (cam1_pix      ),
        .line_done(cam1_line_done),
        .len_err  (cam1_len_err  )
    );

    cam_capture #(.line_w(line_w)) u_cam2_capture (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .href     (cam2_href     ),
        .pclk     (cam2_pclk     ),
        .data     (cam2_data     ),
        .pix_valid(cam2_pix_valid),
        .pix      (cam2_pix      ),
        .line_done(cam2_line_done),
        .len_err  (cam2_len_err  )
    );

    pixel_combine #(.line_w(line_w), .fifo_depth(fifo_depth)) u_pixel_combine (
        .clk        (clk           ),
        .rst_n      (rst_n         ),
        // cam 1
        .valid_1    (cam1_pix_valid),
        .data_1     (cam1_pix      ),
        .line_done_1(cam1_line_done),
        .len_err_1  (cam1_len_err  ),
        // cam 2
        .valid_2    (cam2_pix_valid),
        .data_2     (cam2_pix      ),
        .line_done_2(cam2_line_done),
        .len_err_2  (cam2_len_err  ),
        .valid      (comb_valid    ),
        .pixel_1    (comb_pix_1    ),
        .pixel_2    (comb_pix_2    ),
        .error      (comb_err_p    )
    );

    hsync_gen #(.h_fp(h_fp), .h_sync(h_sync)) u_hsync_gen (
        .clk  (clk       ),
        .rst_n(rst_n     ),
        .de   (comb_valid),
        .hsync(hdmi_hsync)
    );

    err_stretch #(.err_hold(err_hold)) u_err_stretch (
        .clk      (clk       ),
        .rst_n    (rst_n     ),
        .err_pulse(comb_err_p),
        .err_level(comb_err  )
    );

    assign hdmi_de    = comb_valid;
    assign hdmi_vsync = cam1_vsync;  // frame timing follows camera 1

    // RGB565 to 8 bits per channel, low bits zero
    assign hdmi_r  = {comb_pix_1[15:11], 3'b000};
    assign hdmi_g  = {comb_pix_1[10:5], 2'b00};
    assign hdmi_b  = {comb_pix_1[4:0], 3'b000};
    assign aux_pix = comb_pix_2;

endmodule : aimbot_video

/* cam_capture.sv */
`timescale 1ns/1ps

module cam_capture import aimbot_pkg::*; #(
    parameter int line_w = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             href,
    input  logic             pclk,
    input  logic [7:0]       data,
    output logic             pix_valid,
    output logic [pix_w-1:0] pix,
    output logic             line_done,
    output logic             len_err
);

    // one spare code above line_w so a long line stays detectable
    localparam int cnt_w = $clog2(line_w + 2);

    logic             href_q;
    logic             have_hi;
    logic [7:0]       hi_byte;
    logic [cnt_w-1:0] pix_cnt;
    logic             byte_en;
    logic             href_fall;

    assign byte_en   = href & pclk;
    assign href_fall = href_q & ~href;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            href_q    <= 1'b0;
            have_hi   <= 1'b0;
            pix_cnt   <= '0;
            pix_valid <= 1'b0;
            line_done <= 1'b0;
            len_err   <= 1'b0;
        end else begin
            href_q    <= href;
            pix_valid <= byte_en & have_hi;  // second byte of the pair
            line_done <= href_fall;
            len_err   <= href_fall & (have_hi | (pix_cnt != cnt_w'(line_w)));
            if (href_fall) begin
                have_hi <= 1'b0;  // fresh pairing for the next line
                pix_cnt <= '0;
            end else if (byte_en) begin
                have_hi <= ~have_hi;
                if (have_hi && pix_cnt != cnt_w'(line_w + 1)) begin
                    pix_cnt <= pix_cnt + 1'b1;  // saturates one past line_w
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_en && !have_hi) begin
            hi_byte <= data;  // high byte arrives first
        end
        if (byte_en && have_hi) begin
            pix <= {hi_byte, data};
        end
    end

endmodule : cam_capture

/* err_stretch.sv */
`timescale 1ns/1ps

module err_stretch #(
    parameter int err_hold = 20
) (
    input  logic clk,
    input  logic rst_n,
    input  logic err_pulse,
    output logic err_level
);

    localparam int cnt_w = $clog2(err_hold + 1);

    logic [cnt_w-1:0] hold_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (err_pulse) begin
            hold_cnt <= cnt_w'(err_hold);  // every pulse restarts the hold
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign err_level = (hold_cnt != '0);

endmodule : err_stretch

/* hsync_gen.sv */
`timescale 1ns/1ps

module hsync_gen #(
    parameter int h_fp   = 4,
    parameter int h_sync = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic de,
    output logic hsync
);

    localparam int total = h_fp + h_sync;
    localparam int cnt_w = $clog2(total + 1);

    logic             de_q;
    logic             busy;
    logic [cnt_w-1:0] cnt;  // cycles since the first low de cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_q <= 1'b0;
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            de_q <= de;
            if (de_q && !de) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(total - 1)) begin
                    busy <= 1'b0;  // last sync cycle
                end
            end
        end
    end

    // front porch covers cnt below h_fp
    assign hsync = busy && (cnt >= cnt_w'(h_fp)) && (cnt < cnt_w'(total));

endmodule : hsync_gen

/* line_fifo.sv */
`timescale 1ns/1ps

module line_fifo import aimbot_pkg::*; #(
    parameter int depth = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [pix_w-1:0] push_data,
    input  logic             pop,
    output logic [pix_w-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [pix_w-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);
    assign wr_en = push & ~full;  // push into a full buffer is lost
    assign rd_en = pop & ~empty;

    // wrap explicitly so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
        if (rd_en) begin
            pop_data <= mem[rd_ptr];  // registered read
        end
    end

endmodule : line_fifo

/* pixel_combine.sv */
`timescale 1ns/1ps

module pixel_combine import aimbot_pkg::*; #(
    parameter int line_w     = 16,
    parameter int fifo_depth = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_1,
    input  logic [pix_w-1:0] data_1,
    input  logic             line_done_1,
    input  logic             len_err_1,
    input  logic             valid_2,
    input  logic [pix_w-1:0] data_2,
    input  logic             line_done_2,
    input  logic             len_err_2,
    output logic             valid,
    output logic [pix_w-1:0] pixel_1,
    output logic [pix_w-1:0] pixel_2,
    output logic             error
);

    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam int pos_w = $clog2(line_w + 1);

    comb_state_t                 state;
    err_cause_t                  cause;
    logic [pos_w-1:0]            pos;
    logic [1:0]                  push, pop, full, empty, done, len_bad, ovf;
    logic [1:0]                  ovf_line, bad_fin, kill, flush_pop;
    logic [1:0][pix_w-1:0]       push_data, pop_data;
    logic [1:0][cnt_w-1:0]       lines_q, lines_n, flush_q, flush_n, drop_q, drop_n, pend_q;
    logic                        start, stream_pop;

    // index 0 is camera 1, index 1 is camera 2
    assign push      = {valid_2, valid_1};
    assign push_data = {data_2, data_1};
    assign done      = {line_done_2, line_done_1};
    assign len_bad   = {len_err_2, len_err_1};
    assign ovf       = push & full;

    assign bad_fin = done & (len_bad | ovf_line);
    assign kill[0] = bad_fin[0] & (drop_q[0] == '0) & ~bad_fin[1];  // partner line goes too
    assign kill[1] = bad_fin[1] & (drop_q[1] == '0) & ~bad_fin[0];

    assign start = (state == st_idle) && (lines_q[0] != '0) && (lines_q[1] != '0)
                   && (flush_q == '0);
    assign stream_pop = (state == st_stream);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            flush_pop[c] = (state == st_idle) && (flush_q[c] != '0) && !empty[c];
        end
    end

    assign pop = {2{stream_pop}} | flush_pop;

    for (genvar c = 0; c < 2; c++) begin : g_fifo
        line_fifo #(.depth(fifo_depth)) u_line_fifo (
            .clk      (clk         ),
            .rst_n    (rst_n       ),
            .push     (push[c]     ),
            .push_data(push_data[c]),
            .pop      (pop[c]      ),
            .pop_data (pop_data[c] ),
            .full     (full[c]     ),
            .empty    (empty[c]    )
        );
    end

    always_comb begin
        lines_n = lines_q;
        flush_n = flush_q;
        drop_n  = drop_q;
        for (int c = 0; c < 2; c++) begin
            if (start) lines_n[c] = lines_n[c] - 1'b1;
            if (flush_pop[c]) flush_n[c] = flush_n[c] - 1'b1;
            if (done[c]) begin
                if (drop_q[c] != '0 || bad_fin[c]) flush_n[c] = flush_n[c] + pend_q[c];
                else lines_n[c] = lines_n[c] + 1'b1;
                if (drop_q[c] != '0) drop_n[c] = drop_n[c] - 1'b1;
            end
        end
        for (int c = 0; c < 2; c++) begin
            if (kill[c]) begin
                if (lines_n[c ^ 1] != '0) begin  // partner line already complete
                    lines_n[c ^ 1] = lines_n[c ^ 1] - 1'b1;
                    flush_n[c ^ 1] = flush_n[c ^ 1] + cnt_w'(line_w);
                end else if (~&drop_n[c ^ 1]) begin
                    drop_n[c ^ 1] = drop_n[c ^ 1] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            pos      <= '0;
            lines_q  <= '0;
            flush_q  <= '0;
            drop_q   <= '0;
            pend_q   <= '0;
            ovf_line <= '0;
            valid    <= 1'b0;
            error    <= 1'b0;
            cause    <= cause_none;
        end else begin
            lines_q <= lines_n;
            flush_q <= flush_n;
            drop_q  <= drop_n;
            valid   <= stream_pop;  // lines up with the registered FIFO output
            error   <= (|ovf) | (|(done & len_bad));
            if (|(done & len_bad)) cause <= cause_length;
            else if (|ovf) cause <= cause_overflow;
            for (int c = 0; c < 2; c++) begin
                pend_q[c]   <= done[c] ? '0 : pend_q[c] + cnt_w'(push[c] & ~full[c]);
                ovf_line[c] <= done[c] ? 1'b0 : (ovf_line[c] | ovf[c]);
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_stream;
                        pos   <= '0;
                    end
                end
                st_stream: begin
                    pos <= pos + 1'b1;
                    if (pos == pos_w'(line_w - 1)) state <= st_gap;
                end
                st_gap:  state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    assign pixel_1 = pop_data[0];
    assign pixel_2 = pop_data[1];

endmodule : pixel_combine

/* sim.f */
aimbot_pkg.sv
cam_capture.sv
line_fifo.sv
pixel_combine.sv
hsync_gen.sv
err_stretch.sv
aimbot_video.sv
aimbot_assertions.sv
tb_aimbot_video.sv

/* tb_aimbot_video.sv */
`timescale 1ns/1ps

module tb_aimbot_video import aimbot_pkg::*; ();

    localparam int line_w     = 16;
    localparam int fifo_depth = 64;
    localparam int h_fp       = 4;
    localparam int h_sync     = 3;
    localparam int err_hold   = 20;
    localparam int max_cycles = 40 * 200;

    logic             clk, rst_n;
    logic             cam1_vsync, cam1_href, cam1_pclk, cam2_vsync, cam2_href, cam2_pclk;
    logic [7:0]       cam1_data, cam2_data, hdmi_r, hdmi_g, hdmi_b;
    logic             hdmi_de, hdmi_hsync, hdmi_vsync, comb_err;
    logic [pix_w-1:0] aux_pix;

    logic [31:0]      lcg_state;
    logic [pix_w-1:0] exp1_q [$];
    logic [pix_w-1:0] exp2_q [$];
    logic [pix_w-1:0] line_pix [2][128];
    int               gap_len [2][256];
    int               data_errs = 0, sync_errs = 0, other_errs = 0, checks = 0, cycles = 0;
    int               de_run = 0, since_fall = 1000, err_run = 0, err_len = 0;
    logic             de_prev = 1'b0, err_allowed = 1'b0, err_seen = 1'b0;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    aimbot_video #(.line_w(line_w), .fifo_depth(fifo_depth), .h_fp(h_fp), .h_sync(h_sync),
                   .err_hold(err_hold)) dut0 (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RGB565 widened to 8 bits per channel by scaling
    function automatic logic [23:0] expand_rgb(input logic [pix_w-1:0] p);
        logic [7:0] r, g, b;
        r = 8'(p[15:11]) * 8'd8;
        g = 8'(p[10:5]) * 8'd4;
        b = 8'(p[4:0]) * 8'd8;
        return {r, g, b};
    endfunction

    task automatic set_cam(input int cam, input logic href, input logic strobe,
                           input logic [7:0] value);
        if (cam == 0) begin
            cam1_href = href;
            cam1_pclk = strobe;
            cam1_data = value;
        end else begin
            cam2_href = href;
            cam2_pclk = strobe;
            cam2_data = value;
        end
    endtask

    task automatic send_line(input int cam, input int npix, input int delay);
        logic [7:0] b;
        repeat (delay) @(posedge clk);
        for (int i = 0; i < 2 * npix; i++) begin
            b = (i % 2 == 1) ? line_pix[cam][i / 2][7:0] : line_pix[cam][i / 2][15:8];
            for (int g = 0; g < gap_len[cam][i]; g++) begin
                @(posedge clk);
                #1;
                set_cam(cam, 1'b1, 1'b0, 8'h00);  // href high, no strobe
            end
            @(posedge clk);
            #1;
            set_cam(cam, 1'b1, 1'b1, b);
        end
        @(posedge clk);
        #1;
        set_cam(cam, 1'b0, 1'b0, 8'h00);
        repeat (3) @(posedge clk);
    endtask

    // one line on each camera, camera 2 starting a few cycles late
    task automatic run_pair(input int npix_1, input int npix_2, input bit keep);
        logic [31:0] r;
        int          n;
        int          offset;
        for (int c = 0; c < 2; c++) begin
            n = (c == 0) ? npix_1 : npix_2;
            for (int i = 0; i < n; i++) begin
                r = next_rand();
                line_pix[c][i] = r[23:8];
            end
            for (int i = 0; i < 2 * n; i++) begin
                r = next_rand();
                gap_len[c][i] = (r[31:30] == 2'b00) ? int'(r[5:4]) : 0;
            end
        end
        if (keep) begin
            for (int i = 0; i < line_w; i++) begin
                exp1_q.push_back(line_pix[0][i]);
                exp2_q.push_back(line_pix[1][i]);
            end
        end
        r = next_rand();
        offset = int'(r[10:8]) % 6;
        fork
            send_line(0, npix_1, 0);
            send_line(1, npix_2, offset);
        join
    endtask

    always @(negedge clk) begin : compare
        logic [pix_w-1:0] exp_1;
        logic [pix_w-1:0] exp_2;
        if (rst_n) begin
            if (hdmi_de) begin
                de_run++;
                assert (exp1_q.size() != 0 && exp2_q.size() != 0) else begin
                    other_errs++;
                    $display("display enable high at %0t with no pixel pending", $time);
                end
                if (exp1_q.size() != 0 && exp2_q.size() != 0) begin
                    exp_1 = exp1_q.pop_front();
                    exp_2 = exp2_q.pop_front();
                    checks++;
                    assert ({hdmi_r, hdmi_g, hdmi_b} == expand_rgb(exp_1)) else begin
                        data_errs++;
                        $display("ERROR %0t: rgb %h %h %h, expected %h for pixel %h", $time,
                                 hdmi_r, hdmi_g, hdmi_b, expand_rgb(exp_1), exp_1);
                    end
                    assert (aux_pix == exp_2) else begin
                        data_errs++;
                        $display("ERROR %0t: aux_pix %h, expected %h", $time, aux_pix, exp_2);
                    end
                end
            end else if (de_run != 0) begin
                assert (de_run == line_w) else begin
                    other_errs++;
                    $display("line at %0t lasted %0d de cycles instead of %0d", $time, de_run,
                             line_w);
                end
                de_run = 0;
            end
            assert (hdmi_vsync == cam1_vsync) else begin
                data_errs++;
                $display("ERROR %0t: hdmi_vsync %b, expected %b", $time, hdmi_vsync, cam1_vsync);
            end
        end
    end

    always @(negedge clk) begin : sync_watch
        logic exp_hs;
        if (rst_n) begin
            if (de_prev && !hdmi_de) since_fall = 0;  // first blank cycle
            else if (since_fall < 1000) since_fall++;
            exp_hs = (since_fall >= h_fp) && (since_fall < h_fp + h_sync);
            assert (hdmi_hsync == exp_hs) else begin
                sync_errs++;
                $display("ERROR %0t: hdmi_hsync %b, expected %b (%0d cycles after de fell)",
                         $time, hdmi_hsync, exp_hs, since_fall);
            end
            if (comb_err && cam1_href) err_seen = 1'b1;  // overflow shows before the line ends
            if (comb_err) err_run++;
            else if (err_run != 0) begin
                err_len = err_run;  // length of the last error level
                err_run = 0;
            end
            assert (!comb_err || err_allowed) else begin
                other_errs++;
                $display("error level high at %0t although no bad line was sent", $time);
            end
            de_prev = hdmi_de;
        end
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d pixels still expected", max_cycles,
                 exp1_q.size());
        $display("checks %0d, errors data %0d sync %0d other %0d assertions %0d", checks,
                 data_errs, sync_errs, other_errs, dut0.u_aimbot_assertions.fail_cnt);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int guard;
        lcg_state  = 32'hdb28ecb0;
        rst_n      = 1'b0;
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        set_cam(0, 1'b0, 1'b0, 8'h00);
        set_cam(1, 1'b0, 1'b0, 8'h00);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (!hdmi_de && !hdmi_hsync && !comb_err) else begin
                other_errs++;
                $display("outputs not quiet at %0t after reset", $time);
            end
        end
        cam1_vsync = 1'b1;
        cam2_vsync = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        for (int k = 0; k < 12; k++) run_pair(line_w, line_w, 1'b1);

        err_allowed = 1'b1;  // short line on camera 1
        err_len     = 0;
        run_pair(line_w - 1, line_w, 1'b0);
        guard = 0;
        while (err_len == 0 && guard < 100) begin
            @(posedge clk);
            #1;
            guard++;
        end
        assert (err_len == err_hold) else begin
            other_errs++;
            $display("error level held %0d cycles after the short line, not %0d", err_len,
                     err_hold);
        end
        repeat (100) @(posedge clk);
        #1;
        err_allowed = 1'b0;
        for (int k = 0; k < 6; k++) run_pair(line_w, line_w, 1'b1);

        err_allowed = 1'b1;  // long line overflows the camera 1 FIFO
        err_seen    = 1'b0;
        run_pair(80, line_w, 1'b0);
        repeat (100) @(posedge clk);
        #1;
        assert (err_seen) else begin
            other_errs++;
            $display("no error level while the camera 1 FIFO overflowed");
        end
        err_allowed = 1'b0;
        for (int k = 0; k < 6; k++) run_pair(line_w, line_w, 1'b1);

        while (exp1_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        $display("checks %0d, errors data %0d sync %0d other %0d assertions %0d", checks,
                 data_errs, sync_errs, other_errs, dut0.u_aimbot_assertions.fail_cnt);
        if (data_errs + sync_errs + other_errs + dut0.u_aimbot_assertions.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_aimbot_video
